// ==== rtl/ddr_params.svh ====
`ifndef DDR_PARAMS_SVH
`define DDR_PARAMS_SVH

// Width of one app data beat.
`define DDR_DATA_W 128

// Width of the app address bus.
`define DDR_ADDR_W 28

// Burst length field, 1 to 1023 beats.
`define DDR_LEN_W 10

// Address increment between consecutive app commands.
`define DDR_ADDR_STEP 8

// Number of client ports, 1 to 8.
`define DDR_NUM_PORTS 3

`endif

// ==== rtl/ddr_pkg.sv ====
package ddr_pkg;

	// Burst controller states.
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		RD_CMD  = 3'd1,
		RD_WAIT = 3'd2,
		WR_XFER = 3'd3,
		WR_WAIT = 3'd4,
		RD_END  = 3'd5,
		WR_END  = 3'd6
	} ctrl_state_t;

	// Command codes on the app interface.
	typedef enum logic [2:0] {
		CMD_WRITE = 3'd0,
		CMD_READ  = 3'd1
	} app_cmd_t;

	// Direction of a client burst.
	typedef enum logic {
		DIR_READ  = 1'b0,
		DIR_WRITE = 1'b1
	} burst_dir_t;

endpackage

// ==== rtl/burst_if.sv ====
`include "ddr_params.svh"

interface burst_if;
	import ddr_pkg::*;

	// Request side, driven by the requester.
	logic                   req;
	burst_dir_t             dir;
	logic [`DDR_LEN_W-1:0]  len;
	logic [`DDR_ADDR_W-1:0] addr;
	logic [`DDR_DATA_W-1:0] wr_data;

	// Response side, driven by the arbiter or the controller.
	logic                   start;
	logic                   data_req;
	logic                   rd_valid;
	logic [`DDR_DATA_W-1:0] rd_data;
	logic                   finish;

	modport port (
		output req, dir, len, addr, wr_data,
		input  start, data_req, rd_valid, rd_data, finish
	);

	modport arb (
		input  req, dir, len, addr, wr_data,
		output start, data_req, rd_valid, rd_data, finish
	);

	modport ctrl (
		input  req, dir, len, addr, wr_data,
		output start, data_req, rd_valid, rd_data, finish
	);

endinterface

// ==== rtl/burst_port.sv ====
`include "ddr_params.svh"

module burst_port (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd_req,
	input  logic                   wr_req,
	input  logic [`DDR_LEN_W-1:0]  burst_len,
	input  logic [`DDR_ADDR_W-1:0] burst_addr,
	input  logic [`DDR_DATA_W-1:0] wr_data,
	output logic                   busy,
	output logic                   wr_data_req,
	output logic                   rd_data_valid,
	output logic                   burst_finish,
	output logic [`DDR_DATA_W-1:0] rd_data,
	burst_if.port                  bus
);
	import ddr_pkg::*;

	logic                   req_r;
	logic                   busy_r;
	logic                   accept;
	burst_dir_t             dir_r;
	logic [`DDR_LEN_W-1:0]  len_r;
	logic [`DDR_ADDR_W-1:0] addr_r;

	// A new request is only taken when the previous burst has finished.
	assign accept = !busy_r && (rd_req || wr_req);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			req_r  <= 1'b0;
			busy_r <= 1'b0;
		end else if (accept) begin
			req_r  <= 1'b1;
			busy_r <= 1'b1;
		end else begin
			if (bus.start) begin
				req_r <= 1'b0;
			end
			if (bus.finish) begin
				busy_r <= 1'b0;
			end
		end
	end

	// Read wins when both strobes arrive together.
	always_ff @(posedge clk) begin
		if (accept) begin
			dir_r  <= rd_req ? DIR_READ : DIR_WRITE;
			len_r  <= burst_len;
			addr_r <= burst_addr;
		end
	end

	assign bus.req     = req_r;
	assign bus.dir     = dir_r;
	assign bus.len     = len_r;
	assign bus.addr    = addr_r;
	assign bus.wr_data = wr_data;

	assign busy          = busy_r;
	assign wr_data_req   = bus.data_req;
	assign rd_data_valid = bus.rd_valid;
	assign rd_data       = bus.rd_data;
	assign burst_finish  = bus.finish;

endmodule

// ==== rtl/port_arbiter.sv ====
`include "ddr_params.svh"

module port_arbiter (
	input  logic  clk,
	input  logic  rst,
	burst_if.arb  ports [`DDR_NUM_PORTS],
	burst_if.port ctrl
);
	import ddr_pkg::*;

	localparam int NP    = `DDR_NUM_PORTS;
	localparam int SEL_W = (NP > 1) ? $clog2(NP) : 1;

	logic [NP-1:0]          req_vec;
	burst_dir_t             dir_vec [NP];
	logic [`DDR_LEN_W-1:0]  len_vec [NP];
	logic [`DDR_ADDR_W-1:0] addr_vec [NP];
	logic [`DDR_DATA_W-1:0] wdata_vec [NP];

	logic             active;
	logic             found;
	logic [SEL_W-1:0] last_grant;
	logic [SEL_W-1:0] pick;
	logic [SEL_W-1:0] sel;

	for (genvar i = 0; i < NP; i++) begin : g_lane
		assign req_vec[i]   = ports[i].req;
		assign dir_vec[i]   = ports[i].dir;
		assign len_vec[i]   = ports[i].len;
		assign addr_vec[i]  = ports[i].addr;
		assign wdata_vec[i] = ports[i].wr_data;

		// Strobes go to the selected port only, read data is shared.
		assign ports[i].start    = ctrl.start && (sel == SEL_W'(i));
		assign ports[i].data_req = ctrl.data_req && (sel == SEL_W'(i));
		assign ports[i].rd_valid = ctrl.rd_valid && (sel == SEL_W'(i));
		assign ports[i].finish   = ctrl.finish && (sel == SEL_W'(i));
		assign ports[i].rd_data  = ctrl.rd_data;
	end

	// Search starts one past the previous owner and wraps around.
	always_comb begin
		int idx;
		found = 1'b0;
		pick  = last_grant;
		for (int k = 1; k <= NP; k++) begin
			idx = (int'(last_grant) + k) % NP;
			if (!found && req_vec[idx]) begin
				found = 1'b1;
				pick  = SEL_W'(idx);
			end
		end
	end

	assign sel = active ? last_grant : pick;

	assign ctrl.req     = !active && found;
	assign ctrl.dir     = dir_vec[sel];
	assign ctrl.len     = len_vec[sel];
	assign ctrl.addr    = addr_vec[sel];
	assign ctrl.wr_data = wdata_vec[sel];

	// The pointer resets to the last port so that port 0 wins first.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active     <= 1'b0;
			last_grant <= SEL_W'(NP - 1);
		end else if (ctrl.start) begin
			active     <= 1'b1;
			last_grant <= pick;
		end else if (ctrl.finish) begin
			active <= 1'b0;
		end
	end

endmodule

// ==== rtl/ddr_burst_ctrl.sv ====
`include "ddr_params.svh"

module ddr_burst_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	burst_if.ctrl                  bus,
	output logic [`DDR_ADDR_W-1:0] app_addr,
	output ddr_pkg::app_cmd_t      app_cmd,
	output logic                   app_en,
	output logic                   app_wdf_wren,
	output logic                   app_wdf_end,
	output logic [`DDR_DATA_W-1:0] app_wdf_data,
	input  logic [`DDR_DATA_W-1:0] app_rd_data,
	input  logic                   app_rd_data_valid,
	input  logic                   app_rdy,
	input  logic                   app_wdf_rdy,
	input  logic                   init_calib_complete
);
	import ddr_pkg::*;

	ctrl_state_t state;

	logic                  app_en_r;
	logic [`DDR_LEN_W-1:0] cmd_cnt;
	logic [`DDR_LEN_W-1:0] wr_cnt;
	logic [`DDR_LEN_W-1:0] rd_cnt;
	logic [`DDR_LEN_W-1:0] len_m1;

	logic cmd_fire;
	logic wr_fire;
	logic rd_fire;
	logic cmd_last;
	logic wr_last;
	logic rd_last;
	logic cmds_left;

	assign len_m1 = bus.len - 1'b1;

	// Every beat of progress needs calibration to be complete.
	assign app_en   = app_en_r && init_calib_complete;
	assign cmd_fire = app_en && app_rdy;
	assign wr_fire  = (state == WR_XFER) && app_wdf_rdy && init_calib_complete;
	assign rd_fire  = app_rd_data_valid && init_calib_complete &&
		((state == RD_CMD) || (state == RD_WAIT));

	assign cmd_last = (cmd_cnt == len_m1);
	assign wr_last  = (wr_cnt == len_m1);
	assign rd_last  = (rd_cnt == len_m1);

	// Commands still pending after this cycle.
	assign cmds_left = app_en_r && !(cmd_fire && cmd_last);

	// Each write beat is one app word, so every beat is also the last one.
	assign app_wdf_wren = wr_fire;
	assign app_wdf_end  = wr_fire;
	assign app_wdf_data = bus.wr_data;

	assign bus.start    = (state == IDLE) && bus.req && init_calib_complete;
	assign bus.data_req = wr_fire;
	assign bus.rd_valid = rd_fire;
	assign bus.rd_data  = app_rd_data;
	assign bus.finish   = (state == RD_END) || (state == WR_END);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= IDLE;
			app_en_r <= 1'b0;
			cmd_cnt  <= '0;
			wr_cnt   <= '0;
			rd_cnt   <= '0;
		end else begin
			if (cmd_fire) begin
				cmd_cnt <= cmd_cnt + 1'b1;
				if (cmd_last) begin
					app_en_r <= 1'b0;
				end
			end
			if (wr_fire) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
			if (rd_fire) begin
				rd_cnt <= rd_cnt + 1'b1;
			end

			case (state)
				IDLE: begin
					if (bus.start) begin
						app_en_r <= 1'b1;
						cmd_cnt  <= '0;
						wr_cnt   <= '0;
						rd_cnt   <= '0;
						state    <= (bus.dir == DIR_READ) ? RD_CMD : WR_XFER;
					end
				end
				RD_CMD: begin
					if (rd_fire && rd_last) begin
						state <= RD_END;
					end else if (cmd_fire && cmd_last) begin
						state <= RD_WAIT;
					end
				end
				RD_WAIT: begin
					if (rd_fire && rd_last) begin
						state <= RD_END;
					end
				end
				WR_XFER: begin
					// Data may finish before or after the commands.
					if (wr_fire && wr_last) begin
						state <= cmds_left ? WR_WAIT : WR_END;
					end
				end
				WR_WAIT: begin
					if (cmd_fire && cmd_last) begin
						state <= WR_END;
					end
				end
				RD_END: begin
					state <= IDLE;
				end
				WR_END: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Address and command are loaded at start and held under back-pressure.
	always_ff @(posedge clk) begin
		if (bus.start) begin
			app_addr <= bus.addr;
			app_cmd  <= (bus.dir == DIR_READ) ? CMD_READ : CMD_WRITE;
		end else if (cmd_fire) begin
			app_addr <= app_addr + `DDR_ADDR_W'(`DDR_ADDR_STEP);
		end
	end

endmodule

// ==== rtl/ddr_subsys_top.sv ====
`include "ddr_params.svh"

module ddr_subsys_top (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic [`DDR_NUM_PORTS-1:0]              rd_req,
	input  logic [`DDR_NUM_PORTS-1:0]              wr_req,
	input  logic [`DDR_NUM_PORTS*`DDR_LEN_W-1:0]   burst_len,
	input  logic [`DDR_NUM_PORTS*`DDR_ADDR_W-1:0]  burst_addr,
	input  logic [`DDR_NUM_PORTS*`DDR_DATA_W-1:0]  wr_data,
	output logic [`DDR_NUM_PORTS-1:0]              busy,
	output logic [`DDR_NUM_PORTS-1:0]              wr_data_req,
	output logic [`DDR_NUM_PORTS-1:0]              rd_data_valid,
	output logic [`DDR_NUM_PORTS-1:0]              burst_finish,
	output logic [`DDR_DATA_W-1:0]                 rd_data,
	output logic [`DDR_ADDR_W-1:0]                 app_addr,
	output ddr_pkg::app_cmd_t                      app_cmd,
	output logic                                   app_en,
	output logic [`DDR_DATA_W-1:0]                 app_wdf_data,
	output logic                                   app_wdf_end,
	output logic [`DDR_DATA_W/8-1:0]               app_wdf_mask,
	output logic                                   app_wdf_wren,
	input  logic [`DDR_DATA_W-1:0]                 app_rd_data,
	input  logic                                   app_rd_data_valid,
	input  logic                                   app_rdy,
	input  logic                                   app_wdf_rdy,
	input  logic                                   init_calib_complete
);

	localparam int NP = `DDR_NUM_PORTS;

	logic [`DDR_DATA_W-1:0] port_rd_data [NP];

	burst_if port_bus [NP] ();
	burst_if ctrl_bus ();

	for (genvar i = 0; i < NP; i++) begin : g_port
		burst_port port_i (
			.clk           (clk),
			.rst           (rst),
			.rd_req        (rd_req[i]),
			.wr_req        (wr_req[i]),
			.burst_len     (burst_len[i*`DDR_LEN_W +: `DDR_LEN_W]),
			.burst_addr    (burst_addr[i*`DDR_ADDR_W +: `DDR_ADDR_W]),
			.wr_data       (wr_data[i*`DDR_DATA_W +: `DDR_DATA_W]),
			.busy          (busy[i]),
			.wr_data_req   (wr_data_req[i]),
			.rd_data_valid (rd_data_valid[i]),
			.burst_finish  (burst_finish[i]),
			.rd_data       (port_rd_data[i]),
			.bus           (port_bus[i])
		);
	end

	port_arbiter arb_i (
		.clk   (clk),
		.rst   (rst),
		.ports (port_bus),
		.ctrl  (ctrl_bus)
	);

	ddr_burst_ctrl ctrl_i (
		.clk                 (clk),
		.rst                 (rst),
		.bus                 (ctrl_bus),
		.app_addr            (app_addr),
		.app_cmd             (app_cmd),
		.app_en              (app_en),
		.app_wdf_wren        (app_wdf_wren),
		.app_wdf_end         (app_wdf_end),
		.app_wdf_data        (app_wdf_data),
		.app_rd_data         (app_rd_data),
		.app_rd_data_valid   (app_rd_data_valid),
		.app_rdy             (app_rdy),
		.app_wdf_rdy         (app_wdf_rdy),
		.init_calib_complete (init_calib_complete)
	);

	// Read data is broadcast to every port, so one lane carries the shared bus.
	assign rd_data = port_rd_data[0];

	assign app_wdf_mask = '0;

endmodule

// ==== tb/app_mem_model.sv ====
`include "ddr_params.svh"

module app_mem_model (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   app_en,
	input  ddr_pkg::app_cmd_t      app_cmd,
	input  logic [`DDR_ADDR_W-1:0] app_addr,
	input  logic                   app_wdf_wren,
	input  logic [`DDR_DATA_W-1:0] app_wdf_data,
	input  int                     stall_pct,
	output logic                   app_rdy,
	output logic                   app_wdf_rdy,
	output logic                   app_rd_data_valid,
	output logic [`DDR_DATA_W-1:0] app_rd_data
);
	import ddr_pkg::*;

	localparam int LAT = 3;

	logic [`DDR_DATA_W-1:0] mem [logic [`DDR_ADDR_W-1:0]];
	logic [`DDR_ADDR_W-1:0] wr_addr_q [$];
	logic [`DDR_DATA_W-1:0] wr_data_q [$];
	logic                   pipe_vld [LAT];
	logic [`DDR_ADDR_W-1:0] pipe_addr [LAT];
	logic                   rd_hit;
	logic [`DDR_ADDR_W-1:0] rd_hit_addr;

	// Unwritten locations read back a pattern built from the full address.
	function automatic logic [`DDR_DATA_W-1:0] read_word(input logic [`DDR_ADDR_W-1:0] a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return {4{{4'hf, a} ^ 32'h5a5a_a5a5}};
	endfunction

	// Write commands and data beats are matched in arrival order.
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_hit = 1'b0;
			wr_addr_q.delete();
			wr_data_q.delete();
		end else begin
			if (app_en && app_rdy) begin
				if (app_cmd == CMD_READ) begin
					rd_hit      = 1'b1;
					rd_hit_addr = app_addr;
				end else begin
					wr_addr_q.push_back(app_addr);
				end
			end
			if (app_wdf_wren) begin
				wr_data_q.push_back(app_wdf_data);
			end
			while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
				mem[wr_addr_q.pop_front()] = wr_data_q.pop_front();
			end
		end
	end

	always @(negedge clk or posedge rst) begin
		if (rst) begin
			app_rdy           = 1'b0;
			app_wdf_rdy       = 1'b0;
			app_rd_data_valid = 1'b0;
			app_rd_data       = '0;
			for (int i = 0; i < LAT; i++) begin
				pipe_vld[i]  = 1'b0;
				pipe_addr[i] = '0;
			end
		end else begin
			for (int i = LAT - 1; i > 0; i--) begin
				pipe_vld[i]  = pipe_vld[i-1];
				pipe_addr[i] = pipe_addr[i-1];
			end
			pipe_vld[0]       = rd_hit;
			pipe_addr[0]      = rd_hit_addr;
			rd_hit            = 1'b0;
			app_rd_data_valid = pipe_vld[LAT-1];
			app_rd_data       = pipe_vld[LAT-1] ? read_word(pipe_addr[LAT-1]) : '0;
			app_rdy           = int'($urandom % 100) >= stall_pct;
			app_wdf_rdy       = int'($urandom % 100) >= stall_pct;
		end
	end

endmodule

// ==== tb/ddr_assert.sv ====
module ddr_assert (
	input logic clk,
	input logic rst,
	input logic app_en,
	input logic app_wdf_wren,
	input logic app_wdf_rdy,
	input logic init_calib_complete,
	input logic finish
);

	a_wren_rdy: assert property (@(posedge clk) disable iff (rst) app_wdf_wren |-> app_wdf_rdy)
		else $error("app_wdf_wren asserted while app_wdf_rdy is low");

	a_finish_pulse: assert property (@(posedge clk) disable iff (rst) finish |=> !finish)
		else $error("finish held high for more than one cycle");

	a_calib_en: assert property (@(posedge clk) disable iff (rst) !init_calib_complete |-> !app_en)
		else $error("app_en asserted before calibration completed");

endmodule

bind ddr_burst_ctrl ddr_assert assert_i (
	.clk                 (clk),
	.rst                 (rst),
	.app_en              (app_en),
	.app_wdf_wren        (app_wdf_wren),
	.app_wdf_rdy         (app_wdf_rdy),
	.init_calib_complete (init_calib_complete),
	.finish              (bus.finish)
);

// ==== tb/tb_top.sv ====
`include "ddr_params.svh"

module tb_top;
	import ddr_pkg::*;

	localparam int NP      = `DDR_NUM_PORTS;
	localparam int DW      = `DDR_DATA_W;
	localparam int AW      = `DDR_ADDR_W;
	localparam int LW      = `DDR_LEN_W;
	localparam int TIMEOUT = 20000;

	logic             clk;
	logic             rst;
	logic [NP-1:0]    rd_req;
	logic [NP-1:0]    wr_req;
	logic [NP*LW-1:0] burst_len;
	logic [NP*AW-1:0] burst_addr;
	logic [NP*DW-1:0] wr_data = '0;
	logic [NP-1:0]    busy;
	logic [NP-1:0]    wr_data_req;
	logic [NP-1:0]    rd_data_valid;
	logic [NP-1:0]    burst_finish;
	logic [DW-1:0]    rd_data;
	logic [AW-1:0]    app_addr;
	app_cmd_t         app_cmd;
	logic             app_en;
	logic [DW-1:0]    app_wdf_data;
	logic             app_wdf_end;
	logic [DW/8-1:0]  app_wdf_mask;
	logic             app_wdf_wren;
	logic [DW-1:0]    app_rd_data;
	logic             app_rd_data_valid;
	logic             app_rdy;
	logic             app_wdf_rdy;
	logic             init_calib_complete;
	int               stall_pct;

	// Scoreboard state, updated from the clock edge monitor.
	int            fin_cnt [NP];
	int            wr_idx [NP];
	logic [AW-1:0] wr_base [NP];
	logic [31:0]   wr_salt [NP];
	int            en_cnt;
	int            fin_order [$];
	logic [AW-1:0] cmd_log [$];
	logic [DW-1:0] rd_log [$];
	int            rd_src [$];

	ddr_subsys_top dut_i (.*);

	app_mem_model mem_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [DW-1:0] beat_word(input logic [AW-1:0] a, input logic [31:0] salt);
		return {salt, {4'h0, a}, ~salt, salt ^ {4'hc, a}};
	endfunction

	always @(posedge clk) begin
		if (!rst) begin
			for (int p = 0; p < NP; p++) begin
				if (burst_finish[p]) begin
					fin_cnt[p]++;
					fin_order.push_back(p);
				end
				if (wr_data_req[p]) begin
					wr_idx[p]++;
				end
				if (rd_data_valid[p]) begin
					rd_log.push_back(rd_data);
					rd_src.push_back(p);
				end
			end
			if (app_en) begin
				en_cnt++;
				if (app_rdy) begin
					cmd_log.push_back(app_addr);
				end
			end
			// Every write beat is a single app word, and no byte is masked.
			if (app_wdf_wren) begin
				check_val("write end", DW'(1), DW'(app_wdf_end));
			end
			check_val("write mask", '0, DW'(app_wdf_mask));
		end
	end

	// Each lane presents the beat that the next wr_data_req will take.
	always @(negedge clk) begin
		for (int p = 0; p < NP; p++) begin
			wr_data[p*DW +: DW] = beat_word(wr_base[p] + AW'(wr_idx[p] * `DDR_ADDR_STEP), wr_salt[p]);
		end
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_val(input string name, input logic [DW-1:0] exp, input logic [DW-1:0] act);
		if (exp !== act) begin
			abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic issue(input int p, input logic is_read, input int len,
			input logic [AW-1:0] addr, input logic [31:0] salt);
		if (!is_read) begin
			wr_base[p] = addr;
			wr_salt[p] = salt;
			wr_idx[p]  = 0;
		end
		burst_len[p*LW +: LW]  = LW'(len);
		burst_addr[p*AW +: AW] = addr;
		rd_req[p]              = is_read;
		wr_req[p]              = !is_read;
	endtask

	task automatic release_reqs();
		@(negedge clk);
		rd_req = '0;
		wr_req = '0;
	endtask

	task automatic wait_finish(input int p, input int target, input string name);
		int cycles;
		cycles = 0;
		while (fin_cnt[p] < target) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				abort_run($sformatf("Timeout in %s: no burst_finish on port %0d", name, p));
			end
		end
	endtask

	task automatic check_read(input int p, input int len, input logic [AW-1:0] addr,
			input logic [31:0] salt, input string name);
		int n;
		n = 0;
		foreach (rd_log[i]) begin
			if (rd_src[i] == p) begin
				check_val(name, beat_word(addr + AW'(n * `DDR_ADDR_STEP), salt), rd_log[i]);
				n++;
			end
		end
		check_val({name, " beat count"}, DW'(len), DW'(n));
	endtask

	task automatic run_burst(input int p, input logic is_read, input int len,
			input logic [AW-1:0] addr, input logic [31:0] salt, input string name);
		int target;
		target = fin_cnt[p] + 1;
		cmd_log.delete();
		rd_log.delete();
		rd_src.delete();
		issue(p, is_read, len, addr, salt);
		release_reqs();
		wait_finish(p, target, name);
		check_val({name, " commands"}, DW'(len), DW'(cmd_log.size()));
		foreach (cmd_log[i]) begin
			check_val({name, " address"}, DW'(addr + AW'(i * `DDR_ADDR_STEP)), DW'(cmd_log[i]));
		end
		if (is_read) begin
			check_read(p, len, addr, salt, name);
		end else begin
			check_val({name, " write beats"}, DW'(len), DW'(wr_idx[p]));
		end
	endtask

	task automatic test_reset_state();
		check_val("reset busy", '0, DW'(busy));
		check_val("reset burst_finish", '0, DW'(burst_finish));
		check_val("reset wr_data_req", '0, DW'(wr_data_req));
		check_val("reset app_en", '0, DW'(app_en));
	endtask

	task automatic test_single_port();
		run_burst(0, 1'b0, 4, 28'h000_0100, 32'h1111_0000, "single write");
		run_burst(0, 1'b1, 4, 28'h000_0100, 32'h1111_0000, "single read");
	endtask

	task automatic test_calibration();
		int en_before;
		int target;
		init_calib_complete = 1'b0;
		en_before = en_cnt;
		target = fin_cnt[2] + 1;
		issue(2, 1'b0, 6, 28'h000_3000, 32'h3333_0000);
		release_reqs();
		// Observation window with calibration held low.
		repeat (20) @(negedge clk);
		check_val("calib busy", DW'(1), DW'(busy[2]));
		check_val("calib app_en count", DW'(en_before), DW'(en_cnt));
		init_calib_complete = 1'b1;
		wait_finish(2, target, "calib write");
		check_val("calib write beats", DW'(6), DW'(wr_idx[2]));
		run_burst(2, 1'b1, 6, 28'h000_3000, 32'h3333_0000, "calib read");
	endtask

	task automatic all_ports_pass(input logic is_read, input string name);
		int target [NP];
		fin_order.delete();
		rd_log.delete();
		rd_src.delete();
		for (int p = 0; p < NP; p++) begin
			target[p] = fin_cnt[p] + 1;
			issue(p, is_read, 5 + p, AW'(28'h001_0000 + p * 28'h1000), 32'h4444_0000 + p);
		end
		release_reqs();
		for (int p = 0; p < NP; p++) begin
			wait_finish(p, target[p], name);
		end
		check_val({name, " finish count"}, DW'(NP), DW'(fin_order.size()));
		// The last port owned the burst before, so the grants start again at port 0.
		for (int k = 0; k < NP; k++) begin
			check_val({name, " grant order"}, DW'(k), DW'(fin_order[k]));
			if (is_read) begin
				check_read(k, 5 + k, AW'(28'h001_0000 + k * 28'h1000), 32'h4444_0000 + k, name);
			end
		end
	endtask

	task automatic test_stalls();
		stall_pct = 75;
		run_burst(1, 1'b0, 37, 28'h002_0000, 32'h5555_0000, "stall write");
		run_burst(1, 1'b1, 37, 28'h002_0000, 32'h5555_0000, "stall read");
		stall_pct = 20;
	endtask

	task automatic test_length_edges();
		run_burst(0, 1'b0, 1, 28'h004_0000, 32'h6666_0000, "len1 write");
		run_burst(0, 1'b1, 1, 28'h004_0000, 32'h6666_0000, "len1 read");
		run_burst(1, 1'b0, 1023, 28'h005_0000, 32'h7777_0000, "len1023 write");
		run_burst(1, 1'b1, 1023, 28'h005_0000, 32'h7777_0000, "len1023 read");
	endtask

	initial begin
		void'($urandom(32'h9ac3ac5d));
		rst                 = 1'b1;
		rd_req              = '0;
		wr_req              = '0;
		burst_len           = '0;
		burst_addr          = '0;
		init_calib_complete = 1'b1;
		stall_pct           = 20;
		en_cnt              = 0;
		for (int p = 0; p < NP; p++) begin
			fin_cnt[p] = 0;
			wr_idx[p]  = 0;
			wr_base[p] = '0;
			wr_salt[p] = '0;
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;
		test_reset_state();
		test_single_port();
		test_calibration();
		all_ports_pass(1'b0, "all ports write");
		all_ports_pass(1'b1, "all ports read");
		test_stalls();
		test_length_edges();
		$display("Test OK");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/ddr_pkg.sv
rtl/burst_if.sv
rtl/burst_port.sv
rtl/port_arbiter.sv
rtl/ddr_burst_ctrl.sv
rtl/ddr_subsys_top.sv
tb/app_mem_model.sv
tb/ddr_assert.sv
tb/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f tb.f -o sim_tb > build.log 2>&1

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
	exit 0
else
	exit 1
fi
